//--- design/fft_pkg.sv
package fft_pkg;

    typedef logic signed [15:0] sample_t;
    typedef logic [4:0] idx_t;

    localparam int N_POINTS = 32;
    localparam int N_STAGES = 5;
    localparam int TW_FRAC = 14;
    localparam int DRAIN_CYCLES = N_POINTS - 1 + N_STAGES; // Delay slots plus one register per stage

    // Entry k is exp(-j*2*pi*k/32) in Q1.14
    localparam sample_t twiddle_re [16] = '{
        16'sd16384,
        16'sd16069,
        16'sd15137,
        16'sd13623,
        16'sd11585,
        16'sd9102,
        16'sd6270,
        16'sd3196,
        16'sd0,
        -16'sd3196,
        -16'sd6270,
        -16'sd9102,
        -16'sd11585,
        -16'sd13623,
        -16'sd15137,
        -16'sd16069
    };

    localparam sample_t twiddle_im [16] = '{
        16'sd0,
        -16'sd3196,
        -16'sd6270,
        -16'sd9102,
        -16'sd11585,
        -16'sd13623,
        -16'sd15137,
        -16'sd16069,
        -16'sd16384,
        -16'sd16069,
        -16'sd15137,
        -16'sd13623,
        -16'sd11585,
        -16'sd9102,
        -16'sd6270,
        -16'sd3196
    };

    function automatic idx_t bitrev5(input idx_t v);
        idx_t r;
        for (int i = 0; i < 5; i++) begin
            r[i] = v[4 - i];
        end
        return r;
    endfunction

endpackage

//--- design/fft_stream_if.sv
interface fft_stream_if;
    import fft_pkg::*;

    logic    valid; // Low on drain slots
    sample_t re;
    sample_t im;
    idx_t    idx;   // Position of the sample within its frame

    modport src (
        output valid,
        output re,
        output im,
        output idx
    );

    modport dst (
        input valid,
        input re,
        input im,
        input idx
    );

endinterface

//--- design/frame_ctrl.sv
module frame_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid_i,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             adv_o,
    fft_stream_if.src        out
);
    import fft_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        DRAIN
    } state_t;

    state_t     state;
    idx_t       idx_q;
    idx_t       cur_idx;
    logic [5:0] drain_cnt;
    logic       frame_start;

    // A sample outside FILL always opens a new frame
    assign frame_start = in_valid_i && (state != FILL);
    assign cur_idx = frame_start ? '0 : idx_q;

    assign adv_o = in_valid_i || (state == DRAIN);

    assign out.valid = in_valid_i;
    assign out.re = in_valid_i ? in_re_i : '0;
    assign out.im = in_valid_i ? in_im_i : '0;
    assign out.idx = cur_idx; // Keeps counting through the drain so the stages stay in step

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
            idx_q <= '0;
            drain_cnt <= '0;
        end else begin
            if (adv_o) begin
                idx_q <= cur_idx + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (in_valid_i) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (in_valid_i && cur_idx == idx_t'(N_POINTS - 1)) begin
                        state <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    if (in_valid_i) begin
                        state <= FILL; // Next frame takes over the advance
                    end else if (drain_cnt == 6'(DRAIN_CYCLES - 1)) begin
                        state <= IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_frame_contiguous: assert property (@(posedge clk) disable iff (!rst)
        state == FILL |-> in_valid_i)
        else $error("Input valid dropped inside a frame");

endmodule

//--- design/fft_stage.sv
module fft_stage #(
    parameter int STAGE_DELAY = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      adv_i,
    fft_stream_if.dst in,
    fft_stream_if.src out
);
    import fft_pkg::*;

    localparam int SEL_BIT = $clog2(STAGE_DELAY);
    localparam int TW_STEP = (N_POINTS / 2) / STAGE_DELAY;

    sample_t                  dl_re [STAGE_DELAY];
    sample_t                  dl_im [STAGE_DELAY];
    idx_t                     dl_idx [STAGE_DELAY];
    logic [STAGE_DELAY-1:0]   dl_valid;

    sample_t                  head_re;
    sample_t                  head_im;
    logic                     sel;
    logic signed [16:0]       sum_re;
    logic signed [16:0]       sum_im;
    logic signed [16:0]       dif_re;
    logic signed [16:0]       dif_im;
    sample_t                  half_re;
    sample_t                  half_im;
    logic [3:0]               tw_k;
    sample_t                  w_re;
    sample_t                  w_im;
    logic signed [31:0]       p_rr;
    logic signed [31:0]       p_ii;
    logic signed [31:0]       p_ri;
    logic signed [31:0]       p_ir;
    sample_t                  t_rr;
    sample_t                  t_ii;
    sample_t                  t_ri;
    sample_t                  t_ir;
    sample_t                  store_re;
    sample_t                  store_im;
    sample_t                  emit_re;
    sample_t                  emit_im;
    logic                     emit_valid;

    assign head_re = dl_re[STAGE_DELAY-1];
    assign head_im = dl_im[STAGE_DELAY-1];
    assign sel = in.idx[SEL_BIT]; // High on the second half of each butterfly group

    // Both halves are scaled by one half to keep the result in range
    assign sum_re = head_re + in.re;
    assign sum_im = head_im + in.im;
    assign dif_re = head_re - in.re;
    assign dif_im = head_im - in.im;
    assign half_re = dif_re[16:1];
    assign half_im = dif_im[16:1];

    assign tw_k = 4'((in.idx % STAGE_DELAY) * TW_STEP);
    assign w_re = twiddle_re[tw_k];
    assign w_im = twiddle_im[tw_k];

    assign p_rr = half_re * w_re;
    assign p_ii = half_im * w_im;
    assign p_ri = half_re * w_im;
    assign p_ir = half_im * w_re;
    assign t_rr = sample_t'(p_rr >>> TW_FRAC);
    assign t_ii = sample_t'(p_ii >>> TW_FRAC);
    assign t_ri = sample_t'(p_ri >>> TW_FRAC);
    assign t_ir = sample_t'(p_ir >>> TW_FRAC);

    assign store_re = sel ? t_rr - t_ii : in.re;
    assign store_im = sel ? t_ri + t_ir : in.im;
    assign emit_re = sel ? sum_re[16:1] : head_re;
    assign emit_im = sel ? sum_im[16:1] : head_im;
    assign emit_valid = dl_valid[STAGE_DELAY-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dl_valid <= '0;
            out.valid <= 1'b0;
        end else if (adv_i) begin
            dl_valid[0] <= in.valid;
            for (int i = 1; i < STAGE_DELAY; i++) begin
                dl_valid[i] <= dl_valid[i-1];
            end
            out.valid <= emit_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            dl_re[0] <= store_re;
            dl_im[0] <= store_im;
            dl_idx[0] <= in.idx;
            for (int i = 1; i < STAGE_DELAY; i++) begin
                dl_re[i] <= dl_re[i-1];
                dl_im[i] <= dl_im[i-1];
                dl_idx[i] <= dl_idx[i-1];
            end
            out.re <= emit_valid ? emit_re : '0;
            out.im <= emit_valid ? emit_im : '0;
            out.idx <= dl_idx[STAGE_DELAY-1];
        end
    end

    // Butterfly partners come from the same frame, D positions apart
    a_pair_distance: assert property (@(posedge clk) disable iff (!rst)
        (adv_i && sel && in.valid && dl_valid[STAGE_DELAY-1])
        |-> idx_t'(in.idx - dl_idx[STAGE_DELAY-1]) == idx_t'(STAGE_DELAY))
        else $error("Butterfly inputs are not paired at distance %0d", STAGE_DELAY);

endmodule

//--- design/bin_reorder.sv
module bin_reorder (
    input  logic             clk,
    input  logic             rst,
    fft_stream_if.dst        in,
    output logic             out_valid_o,
    output fft_pkg::idx_t    out_bin_o,
    output fft_pkg::sample_t out_re_o,
    output fft_pkg::sample_t out_im_o
);
    import fft_pkg::*;

    sample_t bank_re [2][N_POINTS];
    sample_t bank_im [2][N_POINTS];

    logic    wr_bank;
    logic    rd_bank;
    logic    rd_active;
    idx_t    rd_cnt;
    logic    swap;
    idx_t    wr_addr;

    assign wr_addr = bitrev5(in.idx);
    assign swap = in.valid && (in.idx == idx_t'(N_POINTS - 1)); // Last arrival of a frame
    assign rd_bank = ~wr_bank;

    always_ff @(posedge clk) begin
        if (in.valid) begin
            bank_re[wr_bank][wr_addr] <= in.re;
            bank_im[wr_bank][wr_addr] <= in.im;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_bank <= 1'b0;
            rd_active <= 1'b0;
            rd_cnt <= '0;
        end else begin
            if (rd_active) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == idx_t'(N_POINTS - 1)) begin
                    rd_active <= 1'b0;
                end
            end
            // A new frame may start reading right as the previous one ends
            if (swap) begin
                wr_bank <= ~wr_bank;
                rd_active <= 1'b1;
                rd_cnt <= '0;
            end
        end
    end

    assign out_valid_o = rd_active;
    assign out_bin_o = rd_cnt;
    assign out_re_o = bank_re[rd_bank][rd_cnt];
    assign out_im_o = bank_im[rd_bank][rd_cnt];

    a_no_early_swap: assert property (@(posedge clk) disable iff (!rst)
        swap |-> (!rd_active || rd_cnt == idx_t'(N_POINTS - 1)))
        else $error("Bank swap while a frame is still being read");

endmodule

//--- design/fft32_top.sv
module fft32_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid_i,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             out_valid_o,
    output fft_pkg::idx_t    out_bin_o,
    output fft_pkg::sample_t out_re_o,
    output fft_pkg::sample_t out_im_o
);

    logic adv; // Shared pipeline advance

    fft_stream_if st0 ();
    fft_stream_if st1 ();
    fft_stream_if st2 ();
    fft_stream_if st3 ();
    fft_stream_if st4 ();
    fft_stream_if st5 ();

    frame_ctrl u_frame_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (in_valid_i),
        .in_re_i    (in_re_i),
        .in_im_i    (in_im_i),
        .adv_o      (adv),
        .out        (st0)
    );

    fft_stage #(.STAGE_DELAY(16)) u_stage16 (
        .clk   (clk),
        .rst   (rst),
        .adv_i (adv),
        .in    (st0),
        .out   (st1)
    );

    fft_stage #(.STAGE_DELAY(8)) u_stage8 (
        .clk   (clk),
        .rst   (rst),
        .adv_i (adv),
        .in    (st1),
        .out   (st2)
    );

    fft_stage #(.STAGE_DELAY(4)) u_stage4 (
        .clk   (clk),
        .rst   (rst),
        .adv_i (adv),
        .in    (st2),
        .out   (st3)
    );

    fft_stage #(.STAGE_DELAY(2)) u_stage2 (
        .clk   (clk),
        .rst   (rst),
        .adv_i (adv),
        .in    (st3),
        .out   (st4)
    );

    fft_stage #(.STAGE_DELAY(1)) u_stage1 (
        .clk   (clk),
        .rst   (rst),
        .adv_i (adv),
        .in    (st4),
        .out   (st5)
    );

    bin_reorder u_bin_reorder (
        .clk         (clk),
        .rst         (rst),
        .in          (st5),
        .out_valid_o (out_valid_o),
        .out_bin_o   (out_bin_o),
        .out_re_o    (out_re_o),
        .out_im_o    (out_im_o)
    );

endmodule

//--- tb/fft_tb_model.svh
`ifndef FFT_TB_MODEL_SVH
`define FFT_TB_MODEL_SVH

sample_t stim_re [N_FRAMES][N_POINTS];
sample_t stim_im [N_FRAMES][N_POINTS];
sample_t exp_re [N_FRAMES][N_POINTS];
sample_t exp_im [N_FRAMES][N_POINTS];

// Radix-2 DIF on a whole frame, halving at every stage, then sorted into natural order
function automatic void model_fft(input int f);
    int x_re [N_POINTS];
    int x_im [N_POINTS];
    int d;
    int k;
    int h_re;
    int h_im;
    int t_rr;
    int t_ii;
    int t_ri;
    int t_ir;
    for (int i = 0; i < N_POINTS; i++) begin
        x_re[i] = int'(stim_re[f][i]);
        x_im[i] = int'(stim_im[f][i]);
    end
    for (int s = 0; s < N_STAGES; s++) begin
        d = (N_POINTS / 2) >> s;
        for (int j = 0; j < N_POINTS; j++) begin
            if ((j & d) == 0) begin
                k = (j % d) * ((N_POINTS / 2) / d); // Twiddle exponent of this pair
                h_re = int'(sample_t'((x_re[j] - x_re[j + d]) >>> 1));
                h_im = int'(sample_t'((x_im[j] - x_im[j + d]) >>> 1));
                x_re[j] = int'(sample_t'((x_re[j] + x_re[j + d]) >>> 1));
                x_im[j] = int'(sample_t'((x_im[j] + x_im[j + d]) >>> 1));
                t_rr = int'(sample_t'((h_re * int'(twiddle_re[k])) >>> TW_FRAC));
                t_ii = int'(sample_t'((h_im * int'(twiddle_im[k])) >>> TW_FRAC));
                t_ri = int'(sample_t'((h_re * int'(twiddle_im[k])) >>> TW_FRAC));
                t_ir = int'(sample_t'((h_im * int'(twiddle_re[k])) >>> TW_FRAC));
                x_re[j + d] = int'(sample_t'(t_rr - t_ii));
                x_im[j + d] = int'(sample_t'(t_ri + t_ir));
            end
        end
    end
    for (int b = 0; b < N_POINTS; b++) begin
        exp_re[f][b] = sample_t'(x_re[bitrev5(idx_t'(b))]);
        exp_im[f][b] = sample_t'(x_im[bitrev5(idx_t'(b))]);
    end
endfunction

task automatic send_frame(input int f);
    for (int k = 0; k < N_POINTS; k++) begin
        @(posedge clk);
        in_valid_i <= 1'b1;
        in_re_i <= stim_re[f][k];
        in_im_i <= stim_im[f][k];
    end
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        in_valid_i <= 1'b0;
        in_re_i <= '0;
        in_im_i <= '0;
    end
endtask

// Bins must arrive on consecutive cycles once the first one shows up
task automatic collect_frame(input int f);
    @(negedge clk);
    while (!out_valid_o) begin
        @(negedge clk);
    end
    for (int k = 0; k < N_POINTS; k++) begin
        if (k > 0) begin
            @(negedge clk);
            check_value($sformatf("out_valid_o bin %0d", k), 32'(out_valid_o), 32'd1);
        end
        check_value("out_bin_o", 32'(out_bin_o), 32'(k));
        check_value($sformatf("out_re_o bin %0d", k), 32'(out_re_o), 32'(exp_re[f][k]));
        check_value($sformatf("out_im_o bin %0d", k), 32'(out_im_o), 32'(exp_im[f][k]));
    end
endtask

`endif

//--- tb/fft32_tb.sv
module fft32_tb;
    import fft_pkg::*;

    localparam int N_FRAMES = 12;
    localparam int WATCHDOG_CYCLES = N_FRAMES * (N_POINTS + DRAIN_CYCLES + N_POINTS) + 1000;

    logic    clk;
    logic    rst;
    logic    in_valid_i;
    sample_t in_re_i;
    sample_t in_im_i;
    logic    out_valid_o;
    idx_t    out_bin_o;
    sample_t out_re_o;
    sample_t out_im_o;

    fft32_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_re_i     (in_re_i),
        .in_im_i     (in_im_i),
        .out_valid_o (out_valid_o),
        .out_bin_o   (out_bin_o),
        .out_re_o    (out_re_o),
        .out_im_o    (out_im_o)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            $display("Testbench failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    `include "fft_tb_model.svh"

    task automatic fill_random(input int f);
        for (int k = 0; k < N_POINTS; k++) begin
            stim_re[f][k] = sample_t'($urandom);
            stim_im[f][k] = sample_t'($urandom);
        end
        model_fft(f);
    endtask

    // Sender and collector run side by side so frames can overlap in the pipeline
    task automatic run_frames(input int first, input int count, input int max_gap);
        fork
            begin
                for (int f = first; f < first + count; f++) begin
                    send_frame(f);
                    if (f < first + count - 1 && max_gap > 0) begin
                        idle_cycles(1 + int'($urandom % max_gap));
                    end
                end
                idle_cycles(1);
            end
            begin
                for (int f = first; f < first + count; f++) begin
                    collect_frame(f);
                end
            end
        join
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("out_valid_o", 32'(out_valid_o), 32'd0);
        end
    endtask

    task automatic quiet_after_reset();
        expect_quiet(50);
    endtask

    task automatic impulse_and_constant();
        for (int k = 0; k < N_POINTS; k++) begin
            stim_re[0][k] = (k == 0) ? 16'sd16384 : 16'sd0;
            stim_im[0][k] = '0;
            exp_re[0][k] = 16'sd512; // Impulse spreads evenly over all bins
            exp_im[0][k] = '0;
            stim_re[1][k] = 16'sd8192;
            stim_im[1][k] = '0;
            exp_re[1][k] = (k == 0) ? 16'sd8192 : 16'sd0;
            exp_im[1][k] = '0;
        end
        run_frames(0, 1, 0);
        run_frames(1, 1, 0);
    endtask

    task automatic random_gapped_frames();
        for (int f = 2; f < 8; f++) begin
            fill_random(f);
        end
        run_frames(2, 6, 20);
    endtask

    task automatic back_to_back_frames();
        for (int f = 8; f < 11; f++) begin
            fill_random(f);
        end
        run_frames(8, 3, 0);
    endtask

    task automatic drain_after_idle();
        fill_random(11);
        run_frames(11, 1, 0);
        expect_quiet(150); // Nothing more may come out once the drain is over
    endtask

    initial begin
        void'($urandom(32'h51ca183b));
        clk = 1'b0;
        rst = 1'b0;
        in_valid_i = 1'b0;
        in_re_i = '0;
        in_im_i = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        quiet_after_reset();
        impulse_and_constant();
        random_gapped_frames();
        back_to_back_frames();
        drain_after_idle();
        $display("Testbench passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- compile.f
+incdir+tb
design/fft_pkg.sv
design/fft_stream_if.sv
design/frame_ctrl.sv
design/fft_stage.sv
design/bin_reorder.sv
design/fft32_top.sv
tb/fft32_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fft32_tb -f compile.f -o fft32_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/fft32_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
